// ==== logic/bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// received byte layout, two tag bits above the payload
`define BR_DATA_BITS      6
`define BR_TAG_ADDR       2'b01
`define BR_TAG_DATA       2'b10
`define BR_REGA_BITS      4
`define BR_SUBA_MAX       7

// I2C block register map
`define BR_ADR_CMDR       8'h41
`define BR_ADR_TXDR       8'h44
`define BR_ADR_SR         8'h45
`define BR_ADR_RXDR       8'h47

// command bytes
`define BR_CMD_NOSTRETCH  8'h04
`define BR_CMD_STRETCH    8'h00

// status register bits
`define BR_SR_TIP         7
`define BR_SR_BUSY        6
`define BR_SR_RARC        5
`define BR_SR_SRW         4
`define BR_SR_TRRDY       2
`define BR_SR_TROE        1

`endif

// ==== logic/bridgePkg.sv ====
`include "bridge_settings.svh"

package bridgePkg;

    // --------------------------------------------------
    // bus and host port widths

    typedef logic [7:0] busByte_t;
    typedef logic [7:0] efbAddr_t;

    typedef logic [`BR_DATA_BITS-1:0] payload_t;
    typedef logic [`BR_REGA_BITS-1:0] regAddr_t;

    // counts 0 .. BR_SUBA_MAX
    typedef logic [2:0] subAddr_t;

    // --------------------------------------------------
    // sequencer states

    typedef enum logic [3:0] {
        SeqStart,
        SeqInit1,
        SeqInit2,
        SeqInit3,
        SeqInit4,
        SeqIdle,
        SeqWaitTr,
        SeqIn,
        SeqOut0,
        SeqOut1,
        SeqBusWait
    } seqState_t;

endpackage

// ==== logic/wbMasterPort.sv ====
`timescale 1ns/1ps

module wbMasterPort
    import bridgePkg::*;
(
    input  logic     xclk,
    input  logic     sys_rst,

    // request side
    input  logic     reqStart_i,
    input  efbAddr_t reqAddr_i,
    input  logic     reqWrite_i,
    input  busByte_t reqData_i,
    output logic     reqDone_o,
    output busByte_t rdByte_o,

    // Wishbone master
    output logic     wbCyc_o,
    output logic     wbStb_o,
    output logic     wbWe_o,
    output efbAddr_t wbAdr_o,
    output busByte_t wbDat_o,
    input  busByte_t wbDat_i,
    input  logic     wbAck_i
);

    // one cycle in flight at a time
    logic cycActive;

    // single-beat classic cycle, strobe tracks cycle
    assign wbCyc_o = cycActive;
    assign wbStb_o = cycActive;

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            cycActive <= 1'b0;
            wbWe_o    <= 1'b0;
            wbAdr_o   <= '0;
            wbDat_o   <= '0;
            reqDone_o <= 1'b0;
            rdByte_o  <= '0;
        end else begin
            reqDone_o <= 1'b0;

            if (!cycActive) begin
                // latch the request and open the cycle
                if (reqStart_i) begin
                    cycActive <= 1'b1;
                    wbWe_o    <= reqWrite_i;
                    wbAdr_o   <= reqAddr_i;
                    wbDat_o   <= reqWrite_i ? reqData_i : 8'h00;
                end
            end else if (wbAck_i) begin
                // slave accepted, close the cycle
                cycActive <= 1'b0;
                wbWe_o    <= 1'b0;
                reqDone_o <= 1'b1;

                // only reads return data
                if (!wbWe_o) begin
                    rdByte_o <= wbDat_i;
                end
            end
        end
    end

endmodule

// ==== logic/efbSequencer.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module efbSequencer
    import bridgePkg::*;
(
    input  logic     xclk,
    input  logic     sys_rst,

    input  busByte_t xo_i,

    // to the bus port
    output logic     reqStart_o,
    output efbAddr_t reqAddr_o,
    output logic     reqWrite_o,
    output busByte_t reqData_o,
    input  logic     reqDone_i,
    input  busByte_t rdByte_i,

    // to the host port
    output logic     rxStrobe_o,
    output busByte_t rxByte_o,
    output logic     txDone_o
);

    seqState_t state;
    seqState_t stateNext;
    seqState_t retState;

    // request built this cycle
    logic      issue;
    efbAddr_t  issAddr;
    logic      issWrite;
    busByte_t  issData;
    seqState_t issRet;

    // what the outstanding read targets
    logic pendSr;
    logic pendRx;

    // decoded status flags
    logic txReady;
    logic rxReady;
    logic lastTxNak;
    logic busy;

    // --------------------------------------------------
    // next state and request decode

    always_comb begin
        issue     = 1'b0;
        issAddr   = `BR_ADR_SR;
        issWrite  = 1'b0;
        issData   = 8'h00;
        issRet    = retState;
        stateNext = state;

        case (state)
            SeqStart: begin
                // no clock stretch while the block settles
                issue    = 1'b1;
                issAddr  = `BR_ADR_CMDR;
                issWrite = 1'b1;
                issData  = `BR_CMD_NOSTRETCH;
                issRet   = SeqInit1;
            end
            SeqInit1: begin
                issue  = 1'b1;
                issRet = SeqInit2;
            end
            SeqInit2: begin
                issue = 1'b1;
                if (busy) begin
                    issRet = SeqInit2;
                end else begin
                    // first dummy receive read
                    issAddr = `BR_ADR_RXDR;
                    issRet  = SeqInit3;
                end
            end
            SeqInit3: begin
                issue   = 1'b1;
                issAddr = `BR_ADR_RXDR;
                issRet  = SeqInit4;
            end
            SeqInit4: begin
                issue    = 1'b1;
                issAddr  = `BR_ADR_CMDR;
                issWrite = 1'b1;
                issData  = `BR_CMD_STRETCH;
                issRet   = SeqIdle;
            end
            SeqIdle: begin
                // keep polling until the bus goes busy
                issue  = 1'b1;
                issRet = SeqIdle;
            end
            SeqWaitTr: begin
                if (lastTxNak) begin
                    stateNext = SeqStart;
                end else if (txReady) begin
                    issue    = 1'b1;
                    issAddr  = `BR_ADR_TXDR;
                    issWrite = 1'b1;
                    issData  = xo_i;
                    issRet   = SeqOut0;
                end else if (rxReady) begin
                    issue   = 1'b1;
                    issAddr = `BR_ADR_RXDR;
                    issRet  = SeqIn;
                end else if (!busy) begin
                    stateNext = SeqStart;
                end else begin
                    issue  = 1'b1;
                    issRet = SeqWaitTr;
                end
            end
            SeqIn:      stateNext = SeqIdle;
            SeqOut0:    stateNext = SeqOut1;
            SeqOut1:    stateNext = SeqIdle;
            SeqBusWait: begin
                if (reqDone_i) begin
                    // an idle poll moves on only once the bus reads busy
                    if (retState == SeqIdle && pendSr && rdByte_i[`BR_SR_BUSY]) begin
                        stateNext = SeqWaitTr;
                    end else begin
                        stateNext = retState;
                    end
                end
            end
            default:    stateNext = SeqStart;
        endcase

        if (issue) begin
            stateNext = SeqBusWait;
        end
    end

    // --------------------------------------------------
    // registers

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            state      <= SeqStart;
            retState   <= SeqStart;
            reqStart_o <= 1'b0;
            reqAddr_o  <= '0;
            reqWrite_o <= 1'b0;
            reqData_o  <= '0;
            pendSr     <= 1'b0;
            pendRx     <= 1'b0;
            txReady    <= 1'b0;
            rxReady    <= 1'b0;
            lastTxNak  <= 1'b0;
            busy       <= 1'b0;
            rxStrobe_o <= 1'b0;
            rxByte_o   <= '0;
            txDone_o   <= 1'b0;
        end else begin
            state      <= stateNext;
            reqStart_o <= issue;

            if (issue) begin
                retState   <= issRet;
                reqAddr_o  <= issAddr;
                reqWrite_o <= issWrite;
                reqData_o  <= issData;
                pendSr     <= !issWrite && (issAddr == `BR_ADR_SR);
                pendRx     <= !issWrite && (issAddr == `BR_ADR_RXDR);
            end

            // status decode on a finished SR read
            if (reqDone_i && pendSr) begin
                txReady   <= rdByte_i[`BR_SR_BUSY] & rdByte_i[`BR_SR_TRRDY]
                             & rdByte_i[`BR_SR_SRW] & !rdByte_i[`BR_SR_TIP];
                rxReady   <= rdByte_i[`BR_SR_BUSY] & rdByte_i[`BR_SR_TRRDY]
                             & !rdByte_i[`BR_SR_SRW];
                lastTxNak <= rdByte_i[`BR_SR_BUSY] & rdByte_i[`BR_SR_RARC]
                             & rdByte_i[`BR_SR_SRW] & rdByte_i[`BR_SR_TROE];
                busy      <= rdByte_i[`BR_SR_BUSY];
            end

            // init dummy reads never reach the host
            rxStrobe_o <= reqDone_i && pendRx && (retState == SeqIn);
            if (reqDone_i && pendRx && (retState == SeqIn)) begin
                rxByte_o <= rdByte_i;
            end

            txDone_o <= reqDone_i && (retState == SeqOut0);
        end
    end

endmodule

// ==== logic/hostPort.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module hostPort
    import bridgePkg::*;
(
    input  logic     xclk,
    input  logic     sys_rst,

    // from the sequencer
    input  logic     rxStrobe_i,
    input  busByte_t rxByte_i,
    input  logic     txDone_i,

    // host register port
    output logic     pWr_o,
    output payload_t pD_o,
    output regAddr_t pRwa_o,
    output logic     pRdFinished_o,
    output subAddr_t pRdSubA_o
);

    logic [7:`BR_DATA_BITS] rxTag;
    payload_t               rxPayload;
    logic                   isAddr;
    logic                   isData;

    regAddr_t rwAddr;
    subAddr_t rdSubA;

    // --------------------------------------------------
    // byte classification

    assign rxTag     = rxByte_i[7:`BR_DATA_BITS];
    assign rxPayload = rxByte_i[`BR_DATA_BITS-1:0];

    // other tag codes fall through untouched
    assign isAddr = rxStrobe_i && (rxTag == `BR_TAG_ADDR);
    assign isData = rxStrobe_i && (rxTag == `BR_TAG_DATA);

    // --------------------------------------------------
    // address, sub-address and strobes

    always_ff @(posedge xclk or negedge sys_rst) begin
        if (!sys_rst) begin
            rwAddr        <= '0;
            rdSubA        <= '0;
            pWr_o         <= 1'b0;
            pD_o          <= '0;
            pRdFinished_o <= 1'b0;
            pRwa_o        <= '0;
            pRdSubA_o     <= '0;
        end else begin
            if (isAddr) begin
                rwAddr <= rxPayload[`BR_REGA_BITS-1:0];
            end

            // new address restarts the read burst
            if (isAddr) begin
                rdSubA <= '0;
            end else if (pRdFinished_o) begin
                rdSubA <= (rdSubA == subAddr_t'(`BR_SUBA_MAX)) ? subAddr_t'(0)
                                                               : rdSubA + 3'd1;
            end

            pWr_o <= isData;
            if (isData) begin
                pD_o <= rxPayload;
            end

            pRdFinished_o <= txDone_i;

            // host sees address and sub-address a cycle late
            pRwa_o    <= rwAddr;
            pRdSubA_o <= rdSubA;
        end
    end

endmodule

// ==== logic/i2cBridgeTop.sv ====
`timescale 1ns/1ps

module i2cBridgeTop
    import bridgePkg::*;
(
    input  logic     xclk,
    input  logic     sys_rst,

    // Wishbone master toward the I2C block
    output logic     wbCyc_o,
    output logic     wbStb_o,
    output logic     wbWe_o,
    output efbAddr_t wbAdr_o,
    output busByte_t wbDat_o,
    input  busByte_t wbDat_i,
    input  logic     wbAck_i,

    // outgoing byte from the host
    input  busByte_t xo_i,

    // host register port
    output logic     pWr_o,
    output payload_t pD_o,
    output regAddr_t pRwa_o,
    output logic     pRdFinished_o,
    output subAddr_t pRdSubA_o
);

    // --------------------------------------------------
    // sequencer to bus port

    logic     reqStart;
    efbAddr_t reqAddr;
    logic     reqWrite;
    busByte_t reqData;
    logic     reqDone;
    busByte_t rdByte;

    // sequencer to host port
    logic     rxStrobe;
    busByte_t rxByte;
    logic     txDone;

    wbMasterPort busPort (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .reqStart_i (reqStart),
        .reqAddr_i  (reqAddr),
        .reqWrite_i (reqWrite),
        .reqData_i  (reqData),
        .reqDone_o  (reqDone),
        .rdByte_o   (rdByte),
        .wbCyc_o    (wbCyc_o),
        .wbStb_o    (wbStb_o),
        .wbWe_o     (wbWe_o),
        .wbAdr_o    (wbAdr_o),
        .wbDat_o    (wbDat_o),
        .wbDat_i    (wbDat_i),
        .wbAck_i    (wbAck_i)
    );

    efbSequencer sequencer (
        .xclk       (xclk),
        .sys_rst    (sys_rst),
        .xo_i       (xo_i),
        .reqStart_o (reqStart),
        .reqAddr_o  (reqAddr),
        .reqWrite_o (reqWrite),
        .reqData_o  (reqData),
        .reqDone_i  (reqDone),
        .rdByte_i   (rdByte),
        .rxStrobe_o (rxStrobe),
        .rxByte_o   (rxByte),
        .txDone_o   (txDone)
    );

    hostPort hostRegs (
        .xclk          (xclk),
        .sys_rst       (sys_rst),
        .rxStrobe_i    (rxStrobe),
        .rxByte_i      (rxByte),
        .txDone_i      (txDone),
        .pWr_o         (pWr_o),
        .pD_o          (pD_o),
        .pRwa_o        (pRwa_o),
        .pRdFinished_o (pRdFinished_o),
        .pRdSubA_o     (pRdSubA_o)
    );

endmodule

// ==== test/bridge_sva.sv ====
`timescale 1ns/1ps

module bridgeSva
    import bridgePkg::*;
(
    input logic     xclk,
    input logic     sys_rst,
    input logic     wbCyc_o,
    input logic     wbStb_o,
    input logic     wbWe_o,
    input efbAddr_t wbAdr_o,
    input busByte_t wbDat_o,
    input logic     wbAck_i,
    input logic     pWr_o,
    input logic     pRdFinished_o
);

    // --------------------------------------------------
    // Wishbone cycle rules

    stbInCycle: assert property (@(posedge xclk) disable iff (!sys_rst)
        wbStb_o |-> wbCyc_o) else $error("strobe outside a bus cycle");

    holdUntilAck: assert property (@(posedge xclk) disable iff (!sys_rst)
        (wbStb_o && !wbAck_i) |=> (wbStb_o && $stable(wbWe_o) && $stable(wbAdr_o)
                                   && $stable(wbDat_o)))
        else $error("bus request changed before acknowledge");

    // host strobes are single cycle
    wrSingle: assert property (@(posedge xclk) disable iff (!sys_rst)
        pWr_o |=> !pWr_o) else $error("pWr_o held two cycles");

    finSingle: assert property (@(posedge xclk) disable iff (!sys_rst)
        pRdFinished_o |=> !pRdFinished_o) else $error("pRdFinished_o held two cycles");

endmodule

bind i2cBridgeTop bridgeSva busChecks (
    .xclk          (xclk),
    .sys_rst       (sys_rst),
    .wbCyc_o       (wbCyc_o),
    .wbStb_o       (wbStb_o),
    .wbWe_o        (wbWe_o),
    .wbAdr_o       (wbAdr_o),
    .wbDat_o       (wbDat_o),
    .wbAck_i       (wbAck_i),
    .pWr_o         (pWr_o),
    .pRdFinished_o (pRdFinished_o)
);

// ==== test/bridgeTb.sv ====
`timescale 1ns/1ps
`include "bridge_settings.svh"

module bridgeTb
    import bridgePkg::*;
;
    typedef enum logic [1:0] {OpWrite, OpRead, OpNak, OpIdle} op_t;
    typedef enum logic [2:0] {
        SlvIdle, SlvMasterWrite, SlvMasterRead, SlvNak, SlvBusyOnly
    } slave_t;
    typedef struct packed {
        op_t      op;
        busByte_t value;
        logic     expWr;
        payload_t expPd;
        regAddr_t expRwa;
        subAddr_t expSubA;
    } row_t;

    localparam int NumRows = 19;
    localparam int Timeout = 400;

    logic     xclk;
    logic     sys_rst;
    busByte_t xo_i;
    logic     wbCyc_o, wbStb_o, wbWe_o;
    efbAddr_t wbAdr_o;
    busByte_t wbDat_o;
    busByte_t wbDat_i = 8'h00;
    logic     wbAck_i = 1'b0;
    logic     pWr_o, pRdFinished_o;
    payload_t pD_o;
    regAddr_t pRwa_o;
    subAddr_t pRdSubA_o;

    row_t stimTable [NumRows];

    // command mailbox from stimulus to the register model
    slave_t   cmdMode = SlvIdle;
    busByte_t cmdByte = 8'h00;
    int       cmdSeq = 0;

    // register model state
    slave_t   slaveMode = SlvIdle;
    int       seenSeq = 0;
    busByte_t rxQueue [$];
    efbAddr_t logAdr [$];
    busByte_t logDat [$];
    busByte_t lastTxdr = 8'h00;
    int       srReads = 0, rxdrReads = 0, rxdrAtStretch = 0;
    int       txdrWrites = 0, noStretchWrites = 0, stretchWrites = 0;
    int       waitCnt = 0;
    bit       inCycle = 1'b0;

    // host port monitor
    int       wrPulses = 0, finPulses = 0;
    payload_t lastPd = '0;

    i2cBridgeTop i2cBridgeTop_i (.*);

    initial begin
        xclk = 1'b0;
        forever #10 xclk = ~xclk;
    end

    // --------------------------------------------------
    // I2C block register model

    function automatic busByte_t statusFor(slave_t mode);
        busByte_t s;
        s = '0;
        if (mode != SlvIdle) s[`BR_SR_BUSY] = 1'b1;
        if (mode == SlvMasterWrite || mode == SlvMasterRead) s[`BR_SR_TRRDY] = 1'b1;
        if (mode == SlvMasterRead || mode == SlvNak) s[`BR_SR_SRW] = 1'b1;
        if (mode == SlvNak) begin
            s[`BR_SR_RARC] = 1'b1;
            s[`BR_SR_TROE] = 1'b1;
        end
        return s;
    endfunction

    always @(posedge xclk) begin
        if (cmdSeq != seenSeq) begin
            seenSeq   <= cmdSeq;
            slaveMode <= cmdMode;
            if (cmdMode == SlvMasterWrite) rxQueue.push_back(cmdByte);
        end
        if (!sys_rst) begin
            wbAck_i <= 1'b0;
            inCycle = 1'b0;
        end else if (wbAck_i) begin
            wbAck_i <= 1'b0;
        end else if (wbCyc_o && wbStb_o) begin
            // ack comes 1 to 3 cycles after the cycle opens
            if (!inCycle) begin
                inCycle = 1'b1;
                waitCnt = int'($urandom_range(2, 0));
            end
            if (waitCnt != 0) begin
                waitCnt--;
            end else begin
                inCycle = 1'b0;
                wbAck_i <= 1'b1;
                wbDat_i <= 8'h00;
                if (wbWe_o) begin
                    logAdr.push_back(wbAdr_o);
                    logDat.push_back(wbDat_o);
                    if (wbAdr_o == `BR_ADR_CMDR && wbDat_o == `BR_CMD_NOSTRETCH) begin
                        noStretchWrites++;
                        if (slaveMode == SlvNak) slaveMode <= SlvIdle;
                    end
                    if (wbAdr_o == `BR_ADR_CMDR && wbDat_o == `BR_CMD_STRETCH) begin
                        stretchWrites++;
                        rxdrAtStretch = rxdrReads;
                    end
                    if (wbAdr_o == `BR_ADR_TXDR) begin
                        txdrWrites++;
                        lastTxdr = wbDat_o;
                        if (slaveMode == SlvMasterRead) slaveMode <= SlvIdle;
                    end
                end else if (wbAdr_o == `BR_ADR_SR) begin
                    srReads++;
                    wbDat_i <= statusFor(slaveMode);
                    if (slaveMode == SlvBusyOnly) slaveMode <= SlvIdle;
                end else if (wbAdr_o == `BR_ADR_RXDR) begin
                    rxdrReads++;
                    if (rxQueue.size() > 0) wbDat_i <= rxQueue.pop_front();
                    if (slaveMode == SlvMasterWrite) slaveMode <= SlvIdle;
                end
            end
        end
    end

    always @(posedge xclk) begin
        if (sys_rst && pWr_o) begin
            wrPulses++;
            lastPd = pD_o;
        end
        if (sys_rst && pRdFinished_o) finPulses++;
    end

    // --------------------------------------------------
    // checks and waits

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkValue(string name, int got, int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic waitStretch(int target);
        int n;
        for (n = 0; n < Timeout && stretchWrites < target; n++) @(negedge xclk);
        if (stretchWrites < target) begin
            $display("Timed out waiting for the stretch-enabled command write");
            abortRun();
        end
    endtask

    task automatic waitSrPolls(int count);
        int n;
        int target;
        target = srReads + count;
        for (n = 0; n < Timeout && srReads < target; n++) @(negedge xclk);
        if (srReads < target) begin
            $display("Timed out waiting for status register polls");
            abortRun();
        end
    endtask

    task automatic waitModeIdle();
        int n;
        for (n = 0; n < Timeout && !(seenSeq == cmdSeq && slaveMode == SlvIdle); n++) begin
            @(negedge xclk);
        end
        if (!(seenSeq == cmdSeq && slaveMode == SlvIdle)) begin
            $display("Timed out waiting for the bridge to finish the slave transfer");
            abortRun();
        end
    endtask

    function automatic slave_t modeFor(op_t op);
        case (op)
            OpWrite: return SlvMasterWrite;
            OpRead:  return SlvMasterRead;
            OpNak:   return SlvNak;
            default: return SlvBusyOnly;
        endcase
    endfunction

    task automatic setRow(int i, op_t op, busByte_t value, logic expWr, payload_t expPd,
                          regAddr_t expRwa, subAddr_t expSubA);
        stimTable[i] = '{op, value, expWr, expPd, expRwa, expSubA};
    endtask

    // --------------------------------------------------
    // stimulus

    initial begin
        int i;
        int baseWr, baseFin, baseNs, baseSt, baseTx;
        void'($urandom(32'hf6e8_2927));
        sys_rst = 1'b0;
        xo_i    = 8'h00;

        // address and data tags, a sub-address wrap, then untagged bytes
        setRow(0,  OpWrite, 8'h45, 1'b0, 6'h00, 4'h5, 3'd0);
        setRow(1,  OpWrite, 8'h9A, 1'b1, 6'h1A, 4'h5, 3'd0);
        setRow(2,  OpWrite, 8'hBF, 1'b1, 6'h3F, 4'h5, 3'd0);
        setRow(3,  OpRead,  8'h3C, 1'b0, 6'h00, 4'h5, 3'd1);
        setRow(4,  OpRead,  8'hA5, 1'b0, 6'h00, 4'h5, 3'd2);
        setRow(5,  OpRead,  8'h5A, 1'b0, 6'h00, 4'h5, 3'd3);
        setRow(6,  OpRead,  8'h0F, 1'b0, 6'h00, 4'h5, 3'd4);
        setRow(7,  OpRead,  8'hF0, 1'b0, 6'h00, 4'h5, 3'd5);
        setRow(8,  OpRead,  8'h81, 1'b0, 6'h00, 4'h5, 3'd6);
        setRow(9,  OpRead,  8'h7E, 1'b0, 6'h00, 4'h5, 3'd7);
        setRow(10, OpRead,  8'h33, 1'b0, 6'h00, 4'h5, 3'd0);
        setRow(11, OpWrite, 8'hC7, 1'b0, 6'h00, 4'h5, 3'd0);
        setRow(12, OpRead,  8'h96, 1'b0, 6'h00, 4'h5, 3'd1);
        setRow(13, OpWrite, 8'h07, 1'b0, 6'h00, 4'h5, 3'd1);
        setRow(14, OpWrite, 8'h6B, 1'b0, 6'h00, 4'hB, 3'd0);
        setRow(15, OpWrite, 8'h81, 1'b1, 6'h01, 4'hB, 3'd0);
        setRow(16, OpNak,   8'h00, 1'b0, 6'h00, 4'hB, 3'd0);
        setRow(17, OpIdle,  8'h00, 1'b0, 6'h00, 4'hB, 3'd0);
        setRow(18, OpRead,  8'h24, 1'b0, 6'h00, 4'hB, 3'd1);

        repeat (8) @(posedge xclk);
        sys_rst <= 1'b1;

        // power-up init sequence
        waitStretch(1);
        waitSrPolls(1);
        checkValue("first write address", int'(logAdr[0]), int'(`BR_ADR_CMDR));
        checkValue("first write data", int'(logDat[0]), int'(`BR_CMD_NOSTRETCH));
        checkValue("second write address", int'(logAdr[1]), int'(`BR_ADR_CMDR));
        checkValue("second write data", int'(logDat[1]), int'(`BR_CMD_STRETCH));
        checkValue("init receive reads", rxdrAtStretch, 2);

        for (i = 0; i < NumRows; i++) begin
            baseWr  = wrPulses;
            baseFin = finPulses;
            baseNs  = noStretchWrites;
            baseSt  = stretchWrites;
            baseTx  = txdrWrites;
            @(posedge xclk);
            cmdMode <= modeFor(stimTable[i].op);
            cmdByte <= stimTable[i].value;
            cmdSeq  <= cmdSeq + 1;
            if (stimTable[i].op == OpRead) xo_i <= stimTable[i].value;
            @(negedge xclk);
            waitModeIdle();
            if (stimTable[i].op == OpNak || stimTable[i].op == OpIdle) waitStretch(baseSt + 1);
            waitSrPolls(2);

            checkValue("pWr_o pulses", wrPulses - baseWr, int'(stimTable[i].expWr));
            if (stimTable[i].expWr) checkValue("pD_o", int'(lastPd), int'(stimTable[i].expPd));
            checkValue("pRwa_o", int'(pRwa_o), int'(stimTable[i].expRwa));
            checkValue("pRdSubA_o", int'(pRdSubA_o), int'(stimTable[i].expSubA));
            checkValue("pRdFinished_o pulses", finPulses - baseFin,
                       (stimTable[i].op == OpRead) ? 1 : 0);
            checkValue("transmit writes", txdrWrites - baseTx,
                       (stimTable[i].op == OpRead) ? 1 : 0);
            if (stimTable[i].op == OpRead) begin
                checkValue("transmit data", int'(lastTxdr), int'(stimTable[i].value));
            end
            checkValue("no-stretch writes", noStretchWrites - baseNs,
                       (stimTable[i].op == OpNak || stimTable[i].op == OpIdle) ? 1 : 0);
        end

        // three data bytes and ten master reads in the table
        checkValue("total pWr_o pulses", wrPulses, 3);
        checkValue("total pRdFinished_o pulses", finPulses, 10);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/bridgePkg.sv
logic/wbMasterPort.sv
logic/efbSequencer.sv
logic/hostPort.sv
logic/i2cBridgeTop.sv
test/bridge_sva.sv
test/bridgeTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module bridgeTb -f build.f -o Vbridge
	out=$$(./obj_dir/Vbridge); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
